/* mem_pkg.sv */
package mem_pkg;

    // memory geometry.
    localparam int addr_w      = 8;   // byte address.
    localparam int data_w      = 32;  // one data word.
    localparam int mem_bytes   = 256;
    localparam int mem_latency = 2;   // cycles from request to ready.

    // access width codes, 2'b11 is reserved and always faults.
    typedef enum logic [1:0] {
        acc_8  = 2'b00,
        acc_16 = 2'b01,
        acc_32 = 2'b10
    } mem_width_t;

    // one little-endian memory word, seen as byte or halfword lanes.
    // lane 0 holds the lowest address.
    typedef union packed {
        logic [3:0][7:0]  b;
        logic [1:0][15:0] h;
    } mem_word_u;

endpackage

/* bus_pkg.sv */
package bus_pkg;

    // clients on the shared memory bus.
    localparam int client_cnt = 2;

    // client indices, the higher index wins arbitration.
    localparam int client_fetch = 0;
    localparam int client_lsu   = 1;   // load/store has priority.

    // width of the grant register in the multiplexer.
    localparam int grant_w = 1;

endpackage

/* fetch_port.sv */
module fetch_port (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        fetch_req,
    input  logic [mem_pkg::addr_w-1:0]  fetch_addr,
    output logic                        fetch_ack,
    output logic [mem_pkg::data_w-1:0]  fetch_instr,
    output logic                        fetch_fault,
    output logic                        bus_req,
    output logic [mem_pkg::addr_w-1:0]  bus_addr,
    input  logic                        bus_ready,
    input  logic [mem_pkg::data_w-1:0]  bus_rdata
);

    typedef enum logic [1:0] {
        st_idle,
        st_bus,
        st_done
    } state_t;

    state_t state;
    logic   misaligned;

    assign misaligned = |fetch_addr[1:0];  // instructions are whole words.

    always_ff @(posedge clk) begin
        if (rst) begin
            state       <= st_idle;
            fetch_fault <= 1'b0;
        end else begin
            case (state)
                st_idle: begin
                    if (fetch_req) begin
                        fetch_fault <= misaligned;
                        state       <= misaligned ? st_done : st_bus;
                    end
                end
                st_bus: begin
                    if (bus_ready) state <= st_done;
                end
                st_done: begin
                    // wait for both sides to finish their four phases.
                    if (!fetch_req && !bus_ready) state <= st_idle;
                end
                default: state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == st_bus && bus_ready) fetch_instr <= bus_rdata;
    end

    assign bus_req   = (state == st_bus);
    assign bus_addr  = fetch_addr;
    assign fetch_ack = (state == st_done);

endmodule

/* lsu_port.sv */
module lsu_port (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        lsu_req,
    input  logic                        lsu_we,
    input  mem_pkg::mem_width_t         lsu_width,
    input  logic                        lsu_signed,
    input  logic [mem_pkg::addr_w-1:0]  lsu_addr,
    input  logic [mem_pkg::data_w-1:0]  lsu_wdata,
    output logic                        lsu_ack,
    output logic [mem_pkg::data_w-1:0]  lsu_rdata,
    output logic                        lsu_fault,
    output logic                        bus_req,
    output logic [mem_pkg::addr_w-1:0]  bus_addr,
    output logic                        bus_we,
    output mem_pkg::mem_width_t         bus_width,
    output logic [mem_pkg::data_w-1:0]  bus_wdata,
    input  logic                        bus_ready,
    input  logic [mem_pkg::data_w-1:0]  bus_rdata
);

    import mem_pkg::*;

    typedef enum logic [1:0] {
        st_idle,
        st_bus,
        st_done
    } state_t;

    state_t             state;
    logic               misaligned;
    mem_word_u          rword;
    logic [7:0]         lane8;
    logic [15:0]        lane16;
    logic [data_w-1:0]  load_val;

    assign rword = bus_rdata;

    // natural alignment per width, and load lane extraction.
    always_comb begin
        lane8  = rword.b[lsu_addr[1:0]];
        lane16 = rword.h[lsu_addr[1]];
        case (lsu_width)
            acc_8: begin
                misaligned = 1'b0;
                load_val   = {{24{lsu_signed & lane8[7]}}, lane8};
            end
            acc_16: begin
                misaligned = lsu_addr[0];
                load_val   = {{16{lsu_signed & lane16[15]}}, lane16};
            end
            acc_32: begin
                misaligned = |lsu_addr[1:0];
                load_val   = rword;
            end
            default: begin
                misaligned = 1'b1;  // reserved width code.
                load_val   = rword;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= st_idle;
            lsu_fault <= 1'b0;
        end else begin
            case (state)
                st_idle: begin
                    if (lsu_req) begin
                        lsu_fault <= misaligned;
                        state     <= misaligned ? st_done : st_bus;
                    end
                end
                st_bus: begin
                    if (bus_ready) state <= st_done;
                end
                st_done: begin
                    if (!lsu_req && !bus_ready) state <= st_idle;
                end
                default: state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == st_bus && bus_ready) lsu_rdata <= load_val;
    end

    // store data goes into every lane of its size.
    always_comb begin
        case (lsu_width)
            acc_8:   bus_wdata = {4{lsu_wdata[7:0]}};
            acc_16:  bus_wdata = {2{lsu_wdata[15:0]}};
            default: bus_wdata = lsu_wdata;
        endcase
    end

    assign bus_req   = (state == st_bus);
    assign bus_addr  = lsu_addr;
    assign bus_we    = lsu_we;
    assign bus_width = lsu_width;
    assign lsu_ack   = (state == st_done);

endmodule

/* mem_mux.sv */
module mem_mux (
    input  logic                            clk,
    input  logic                            rst,
    input  logic [bus_pkg::client_cnt-1:0]  client_req,
    input  logic [mem_pkg::addr_w-1:0]      client_addr [bus_pkg::client_cnt],
    input  logic [bus_pkg::client_cnt-1:0]  client_we,
    input  mem_pkg::mem_width_t             client_width [bus_pkg::client_cnt],
    input  logic [mem_pkg::data_w-1:0]      client_wdata [bus_pkg::client_cnt],
    output logic [bus_pkg::client_cnt-1:0]  client_ready,
    output logic [mem_pkg::data_w-1:0]      client_rdata [bus_pkg::client_cnt],
    output logic                            mem_request,
    output logic [mem_pkg::addr_w-1:0]      mem_addr,
    output mem_pkg::mem_width_t             mem_width,
    output logic                            mem_we,
    output logic [mem_pkg::data_w-1:0]      mem_wdata,
    input  logic                            mem_ready,
    input  logic [mem_pkg::data_w-1:0]      mem_rdata
);

    import bus_pkg::*;

    typedef enum logic [1:0] {
        st_idle,
        st_wait,
        st_hold
    } state_t;

    state_t             state;
    logic [grant_w-1:0] grant;  // client that owns the memory.
    logic [grant_w-1:0] pick;
    logic [grant_w-1:0] sel;

    // highest index requester wins.
    always_comb begin
        pick = '0;
        for (int i = 0; i < client_cnt; i++) begin
            if (client_req[i]) pick = grant_w'(i);
        end
    end

    // in idle the new winner drives the bus in the same cycle.
    assign sel = (state == st_idle) ? pick : grant;

    always_comb begin
        mem_addr  = client_addr[sel];
        mem_width = client_width[sel];
        mem_we    = client_we[sel];
        mem_wdata = client_wdata[sel];
        case (state)
            st_idle: mem_request = |client_req;
            st_wait: mem_request = 1'b1;
            st_hold: mem_request = client_req[grant];
            default: mem_request = 1'b0;
        endcase
    end

    // only the owner sees ready and data, others are held off.
    always_comb begin
        for (int i = 0; i < client_cnt; i++) begin
            client_ready[i] = (grant_w'(i) == grant) && mem_ready;
            client_rdata[i] = (grant_w'(i) == grant) ? mem_rdata : '0;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= st_idle;
            grant <= '0;
        end else begin
            case (state)
                st_idle: begin
                    if (|client_req) begin
                        grant <= pick;
                        state <= st_wait;
                    end
                end
                st_wait: begin
                    if (mem_ready) state <= st_hold;
                end
                st_hold: begin
                    if (!client_req[grant]) state <= st_idle;  // owner finished.
                end
                default: state <= st_idle;
            endcase
        end
    end

endmodule

/* mem_array.sv */
module mem_array (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        mem_request,
    input  logic [mem_pkg::addr_w-1:0]  mem_addr,
    input  mem_pkg::mem_width_t         mem_width,
    input  logic                        mem_we,
    input  logic [mem_pkg::data_w-1:0]  mem_wdata,
    output logic                        mem_ready,
    output logic [mem_pkg::data_w-1:0]  mem_rdata
);

    import mem_pkg::*;

    logic [7:0]                     mem [mem_bytes];
    logic [$clog2(mem_latency):0]   cnt;
    logic                           fire;
    logic [addr_w-1:0]              base;
    mem_word_u                      wword;
    mem_word_u                      rword;

    assign base  = {mem_addr[addr_w-1:2], 2'b00};
    assign wword = mem_wdata;

    // last wait cycle of a request.
    assign fire = mem_request && !mem_ready && (cnt == ($bits(cnt))'(mem_latency - 1));

    always_ff @(posedge clk) begin
        if (rst) begin
            mem_ready <= 1'b0;
            cnt       <= '0;
        end else if (!mem_request) begin
            mem_ready <= 1'b0;
            cnt       <= '0;
        end else if (fire) begin
            mem_ready <= 1'b1;
            cnt       <= '0;
        end else if (!mem_ready) begin
            cnt <= cnt + 1'b1;
        end
    end

    // aligned word around the address.
    always_comb begin
        for (int i = 0; i < 4; i++) begin
            rword.b[i] = mem[{base[addr_w-1:2], 2'(i)}];
        end
    end

    always_ff @(posedge clk) begin
        if (fire) begin
            mem_rdata <= rword;
            if (mem_we) begin
                case (mem_width)
                    acc_8: mem[mem_addr] <= wword.b[mem_addr[1:0]];
                    acc_16: begin
                        mem[{mem_addr[addr_w-1:1], 1'b0}] <= wword.h[mem_addr[1]][7:0];
                        mem[{mem_addr[addr_w-1:1], 1'b1}] <= wword.h[mem_addr[1]][15:8];
                    end
                    acc_32: begin
                        for (int i = 0; i < 4; i++) begin
                            mem[{base[addr_w-1:2], 2'(i)}] <= wword.b[i];
                        end
                    end
                    default: ;  // reserved code writes nothing.
                endcase
            end
        end
    end

endmodule

/* mem_subsys.sv */
module mem_subsys (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        fetch_req,
    input  logic [mem_pkg::addr_w-1:0]  fetch_addr,
    output logic                        fetch_ack,
    output logic [mem_pkg::data_w-1:0]  fetch_instr,
    output logic                        fetch_fault,
    input  logic                        lsu_req,
    input  logic                        lsu_we,
    input  mem_pkg::mem_width_t         lsu_width,
    input  logic                        lsu_signed,
    input  logic [mem_pkg::addr_w-1:0]  lsu_addr,
    input  logic [mem_pkg::data_w-1:0]  lsu_wdata,
    output logic                        lsu_ack,
    output logic [mem_pkg::data_w-1:0]  lsu_rdata,
    output logic                        lsu_fault
);

    import mem_pkg::*;
    import bus_pkg::*;

    logic [client_cnt-1:0]  client_req;
    logic [addr_w-1:0]      client_addr [client_cnt];
    logic [client_cnt-1:0]  client_we;
    mem_width_t             client_width [client_cnt];
    logic [data_w-1:0]      client_wdata [client_cnt];
    logic [client_cnt-1:0]  client_ready;
    logic [data_w-1:0]      client_rdata [client_cnt];

    logic                   mem_request;
    logic [addr_w-1:0]      mem_addr;
    mem_width_t             mem_width;
    logic                   mem_we;
    logic [data_w-1:0]      mem_wdata;
    logic                   mem_ready;
    logic [data_w-1:0]      mem_rdata;

    // fetch only reads whole words.
    assign client_we[client_fetch]    = 1'b0;
    assign client_width[client_fetch] = acc_32;
    assign client_wdata[client_fetch] = '0;

    fetch_port u_fetch (
        .clk         (clk),
        .rst         (rst),
        .fetch_req   (fetch_req),
        .fetch_addr  (fetch_addr),
        .fetch_ack   (fetch_ack),
        .fetch_instr (fetch_instr),
        .fetch_fault (fetch_fault),
        .bus_req     (client_req[client_fetch]),
        .bus_addr    (client_addr[client_fetch]),
        .bus_ready   (client_ready[client_fetch]),
        .bus_rdata   (client_rdata[client_fetch])
    );

    lsu_port u_lsu (
        .clk        (clk),
        .rst        (rst),
        .lsu_req    (lsu_req),
        .lsu_we     (lsu_we),
        .lsu_width  (lsu_width),
        .lsu_signed (lsu_signed),
        .lsu_addr   (lsu_addr),
        .lsu_wdata  (lsu_wdata),
        .lsu_ack    (lsu_ack),
        .lsu_rdata  (lsu_rdata),
        .lsu_fault  (lsu_fault),
        .bus_req    (client_req[client_lsu]),
        .bus_addr   (client_addr[client_lsu]),
        .bus_we     (client_we[client_lsu]),
        .bus_width  (client_width[client_lsu]),
        .bus_wdata  (client_wdata[client_lsu]),
        .bus_ready  (client_ready[client_lsu]),
        .bus_rdata  (client_rdata[client_lsu])
    );

    mem_mux u_mux (
        .clk          (clk),
        .rst          (rst),
        .client_req   (client_req),
        .client_addr  (client_addr),
        .client_we    (client_we),
        .client_width (client_width),
        .client_wdata (client_wdata),
        .client_ready (client_ready),
        .client_rdata (client_rdata),
        .mem_request  (mem_request),
        .mem_addr     (mem_addr),
        .mem_width    (mem_width),
        .mem_we       (mem_we),
        .mem_wdata    (mem_wdata),
        .mem_ready    (mem_ready),
        .mem_rdata    (mem_rdata)
    );

    mem_array u_mem (
        .clk         (clk),
        .rst         (rst),
        .mem_request (mem_request),
        .mem_addr    (mem_addr),
        .mem_width   (mem_width),
        .mem_we      (mem_we),
        .mem_wdata   (mem_wdata),
        .mem_ready   (mem_ready),
        .mem_rdata   (mem_rdata)
    );

endmodule

/* mem_subsys_chk.sv */
module mem_subsys_chk (
    input  logic                            clk,
    input  logic                            rst,
    input  logic [bus_pkg::client_cnt-1:0]  client_ready,
    input  logic                            mem_request,
    input  logic                            mem_ready,
    input  logic                            lsu_req,
    input  logic                            lsu_ack
);

    timeunit 1ns;
    timeprecision 1ns;

    int violations = 0;  // read by the testbench at the end of the run.

    // the memory answers one owner at a time.
    ready_exclusive: assert property (@(posedge clk) disable iff (rst)
        $onehot0(client_ready))
        else begin
            violations++;
            $error("client readies high together: %b", client_ready);
        end

    request_held: assert property (@(posedge clk) disable iff (rst)
        mem_request && !mem_ready |=> mem_request)
        else begin
            violations++;
            $error("mem_request dropped before mem_ready");
        end

    ack_needs_req: assert property (@(posedge clk) disable iff (rst)
        $rose(lsu_ack) |-> lsu_req)
        else begin
            violations++;
            $error("lsu_ack rose while lsu_req was low");
        end

endmodule

bind mem_subsys mem_subsys_chk u_chk (
    .clk          (clk),
    .rst          (rst),
    .client_ready (client_ready),
    .mem_request  (mem_request),
    .mem_ready    (mem_ready),
    .lsu_req      (lsu_req),
    .lsu_ack      (lsu_ack)
);

/* tb_mem_subsys.sv */
module tb_mem_subsys;

    timeunit 1ns;
    timeprecision 1ns;

    import mem_pkg::*;

    localparam int n_trans     = 208;  // 80 + 64 + 16 + 8 + 40 transactions.
    localparam int cycle_limit = 40 * n_trans;

    logic               clk;
    logic               rst;
    logic               fetch_req;
    logic [addr_w-1:0]  fetch_addr;
    logic               fetch_ack;
    logic [data_w-1:0]  fetch_instr;
    logic               fetch_fault;
    logic               lsu_req;
    logic               lsu_we;
    mem_width_t         lsu_width;
    logic               lsu_signed;
    logic [addr_w-1:0]  lsu_addr;
    logic [data_w-1:0]  lsu_wdata;
    logic               lsu_ack;
    logic [data_w-1:0]  lsu_rdata;
    logic               lsu_fault;

    logic [7:0]         ref_mem [mem_bytes];  // byte image of the memory.
    logic [data_w-1:0]  exp_lsu_rdata;
    logic [data_w-1:0]  exp_fetch_instr;
    logic               exp_lsu_fault;
    logic               exp_lsu_load;
    logic               exp_fetch_fault;
    logic               lsu_seen;
    logic               fetch_seen;
    int                 err_cnt;
    int                 pass_cnt;
    int                 fail_cnt;
    int                 cycles;

    mem_subsys UUT (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic logic [data_w-1:0] ref_load(input logic [addr_w-1:0] addr,
                                                   input logic [1:0] width, input logic sgn);
        logic [7:0]  b;
        logic [15:0] h;
        b = ref_mem[addr];
        h = {ref_mem[addr + 8'd1], ref_mem[addr]};
        case (width)
            2'b00:   ref_load = {{24{sgn & b[7]}}, b};
            2'b01:   ref_load = {{16{sgn & h[15]}}, h};
            default: ref_load = {ref_mem[addr + 8'd3], ref_mem[addr + 8'd2], h};
        endcase
    endfunction

    task automatic ref_store(input logic [addr_w-1:0] addr, input logic [1:0] width,
                             input logic [data_w-1:0] d);
        ref_mem[addr] = d[7:0];
        if (width != acc_8) ref_mem[addr + 8'd1] = d[15:8];
        if (width == acc_32) begin
            ref_mem[addr + 8'd2] = d[23:16];
            ref_mem[addr + 8'd3] = d[31:24];
        end
    endtask

    task automatic lsu_access(input logic we, input logic [1:0] width, input logic sgn,
                              input logic [addr_w-1:0] addr, input logic [data_w-1:0] d);
        logic bad;
        bad = (width == 2'b11) || (width == acc_16 && addr[0])
            || (width == acc_32 && addr[1:0] != 2'b00);
        exp_lsu_fault = bad;
        exp_lsu_load  = !we && !bad;
        exp_lsu_rdata = ref_load(addr, width, sgn);
        @(posedge clk);
        lsu_req    <= 1'b1;
        lsu_we     <= we;
        lsu_width  <= mem_width_t'(width);
        lsu_signed <= sgn;
        lsu_addr   <= addr;
        lsu_wdata  <= d;
        @(negedge clk);
        while (!lsu_ack) @(negedge clk);
        if (we && !bad) ref_store(addr, width, d);
        @(posedge clk);
        lsu_req <= 1'b0;
        @(negedge clk);
        while (lsu_ack) @(negedge clk);
    endtask

    task automatic fetch_word(input logic [addr_w-1:0] addr);
        exp_fetch_fault = |addr[1:0];
        exp_fetch_instr = ref_load(addr & 8'hfc, acc_32, 1'b0);
        @(posedge clk);
        fetch_req  <= 1'b1;
        fetch_addr <= addr;
        @(negedge clk);
        while (!fetch_ack) @(negedge clk);
        @(posedge clk);
        fetch_req <= 1'b0;
        @(negedge clk);
        while (fetch_ack) @(negedge clk);
    endtask

    task automatic report_test(input int num, input string what, input int start);
        if (err_cnt == start) begin
            pass_cnt++;
            $display("test %0d ok: %s", num, what);
        end else begin
            fail_cnt++;
            $display("test %0d bad: %s, %0d errors", num, what, err_cnt - start);
        end
    endtask

    // compare at the first low clock phase of each ack.
    always @(negedge clk) begin
        if (lsu_ack && !lsu_seen) begin
            if (lsu_fault !== exp_lsu_fault) begin
                $display("Mismatch lsu_fault at %h: got %h expected %h",
                         lsu_addr, lsu_fault, exp_lsu_fault);
                err_cnt++;
            end
            if (exp_lsu_load && lsu_rdata !== exp_lsu_rdata) begin
                $display("Mismatch lsu_rdata at %h: got %h expected %h",
                         lsu_addr, lsu_rdata, exp_lsu_rdata);
                err_cnt++;
            end
        end
        if (fetch_ack && !fetch_seen) begin
            if (fetch_fault !== exp_fetch_fault) begin
                $display("Mismatch fetch_fault at %h: got %h expected %h",
                         fetch_addr, fetch_fault, exp_fetch_fault);
                err_cnt++;
            end
            if (!exp_fetch_fault && fetch_instr !== exp_fetch_instr) begin
                $display("Mismatch fetch_instr at %h: got %h expected %h",
                         fetch_addr, fetch_instr, exp_fetch_instr);
                err_cnt++;
            end
        end
        lsu_seen   = lsu_ack;
        fetch_seen = fetch_ack;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= cycle_limit) begin
            $display("timeout: no end of the run after %0d cycles", cycles);
            $display("tests failed");
            $finish;
        end
    end

    initial begin
        logic [addr_w-1:0] a;
        logic [addr_w-1:0] b;
        logic [data_w-1:0] d;
        int                start;
        void'($urandom(85));
        rst        = 1'b1;
        fetch_req  = 1'b0;
        fetch_addr = '0;
        lsu_req    = 1'b0;
        lsu_we     = 1'b0;
        lsu_width  = acc_32;
        lsu_signed = 1'b0;
        lsu_addr   = '0;
        lsu_wdata  = '0;
        lsu_seen   = 1'b0;
        fetch_seen = 1'b0;
        err_cnt    = 0;
        pass_cnt   = 0;
        fail_cnt   = 0;
        cycles     = 0;
        repeat (3) @(posedge clk);
        rst <= 1'b0;

        start = err_cnt;  // fills every word, so later reads are defined.
        for (int i = 0; i < 64; i++) lsu_access(1'b1, acc_32, 1'b0, 8'(i * 4), $urandom);
        for (int i = 0; i < 16; i++) lsu_access(1'b0, acc_32, 1'b0, 8'($urandom) & 8'hfc, '0);
        report_test(1, "aligned word store and load", start);

        start = err_cnt;
        for (int i = 0; i < 8; i++) begin
            a     = 8'($urandom) & 8'hfc;
            d     = $urandom;
            d[7]  = i[0];   // both sign cases for bytes and halfwords.
            d[15] = ~i[0];
            lsu_access(1'b1, acc_32, 1'b0, a, $urandom);
            b = a | 8'($urandom % 4);
            lsu_access(1'b1, acc_8, 1'b0, b, d);
            lsu_access(1'b0, acc_8, 1'b1, b, '0);
            lsu_access(1'b0, acc_8, 1'b0, b, '0);
            b = a | 8'(2 * ($urandom % 2));
            lsu_access(1'b1, acc_16, 1'b0, b, d);
            lsu_access(1'b0, acc_16, 1'b1, b, '0);
            lsu_access(1'b0, acc_16, 1'b0, b, '0);
            lsu_access(1'b0, acc_32, 1'b0, a, '0);
        end
        report_test(2, "byte and halfword lanes with extension", start);

        start = err_cnt;
        for (int i = 0; i < 16; i++) fetch_word(8'($urandom) & 8'hfc);
        report_test(3, "fetch of stored words", start);

        start = err_cnt;
        a = 8'($urandom) & 8'hfc;
        lsu_access(1'b1, acc_32, 1'b0, a, $urandom);
        lsu_access(1'b1, acc_16, 1'b0, a | 8'd1, $urandom);
        lsu_access(1'b1, acc_32, 1'b0, a | 8'd2, $urandom);
        lsu_access(1'b1, 2'b11, 1'b0, a, $urandom);
        lsu_access(1'b0, acc_16, 1'b1, a | 8'd3, '0);
        fetch_word(a | 8'd2);
        lsu_access(1'b0, acc_32, 1'b0, a, '0);
        fetch_word(a);
        report_test(4, "misaligned and reserved accesses fault", start);

        start = err_cnt;
        for (int i = 0; i < 8; i++) begin
            a = 8'($urandom) & 8'hfc;
            b = a + ((8'($urandom) | 8'd1) << 2);  // always another word.
            d = $urandom;
            fork
                lsu_access(1'b1, acc_32, 1'b0, a, d);
                fetch_word(b);
            join
            fetch_word(a);
            fork
                lsu_access(1'b0, acc_32, 1'b0, b, '0);
                fetch_word(a);
            join
        end
        report_test(5, "concurrent fetch and load/store", start);

        $display("pass count %0d, fail count %0d, assertion errors %0d",
                 pass_cnt, fail_cnt, UUT.u_chk.violations);
        if (fail_cnt == 0 && UUT.u_chk.violations == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

/* filelist.f */
mem_pkg.sv
bus_pkg.sv
fetch_port.sv
lsu_port.sv
mem_mux.sv
mem_array.sv
mem_subsys.sv
mem_subsys_chk.sv
tb_mem_subsys.sv

/* run.sh */
#!/bin/sh
# build and run the testbench, pass only if the log holds the pass line.
rm -f sim.log
verilator --binary --timing --assert --top-module tb_mem_subsys -f filelist.f -o sim_tb \
    && ./obj_dir/sim_tb +verilator+error+limit+100 > sim.log 2>&1
cat sim.log 2>/dev/null
grep -qx "all tests passed" sim.log 2>/dev/null && echo "RESULT: PASS" && exit 0 \
    || { echo "RESULT: FAIL"; exit 1; }
